/* logic/vdc_regs_pkg.sv */
// Register numbers, bus byte type and memory command codes shared by the VDC register file and RAM sequencer
package vdc_regs_pkg;

	typedef logic [7:0] db_t;       // CPU data bus byte
	typedef logic [5:0] reg_sel_t;  // Internal register number
	typedef logic [1:0] mem_op_t;   // Command to the RAM sequencer

	// Internal register numbers, as latched through the address port
	localparam reg_sel_t R_HT    = 6'd0;   // Horizontal total minus 1
	localparam reg_sel_t R_HD    = 6'd1;   // Horizontal displayed
	localparam reg_sel_t R_HP    = 6'd2;   // Horizontal sync position
	localparam reg_sel_t R_SYNCW = 6'd3;   // Vsync width high nibble, hsync width low
	localparam reg_sel_t R_VT    = 6'd4;   // Vertical total minus 1
	localparam reg_sel_t R_VD    = 6'd6;   // Vertical displayed
	localparam reg_sel_t R_VP    = 6'd7;   // Vertical sync position
	localparam reg_sel_t R_LPV   = 6'd16;  // Light pen line
	localparam reg_sel_t R_LPH   = 6'd17;  // Light pen column
	localparam reg_sel_t R_UAH   = 6'd18;  // Update address high
	localparam reg_sel_t R_UAL   = 6'd19;  // Update address low
	localparam reg_sel_t R_MODE  = 6'd24;  // Bit 7 selects block copy
	localparam reg_sel_t R_WC    = 6'd30;  // Word count, write starts a block
	localparam reg_sel_t R_DA    = 6'd31;  // Data port into video RAM
	localparam reg_sel_t R_BAH   = 6'd32;  // Block copy source high
	localparam reg_sel_t R_BAL   = 6'd33;  // Block copy source low
	localparam reg_sel_t R_POL   = 6'd37;  // Sync polarity, 8568 only

	// Memory commands carried by the req/ack handshake
	localparam mem_op_t OP_LOAD  = 2'd0;   // Data latch from RAM at update address
	localparam mem_op_t OP_WRITE = 2'd1;   // Data byte to RAM at update address
	localparam mem_op_t OP_FILL  = 2'd2;   // Block fill with data latch
	localparam mem_op_t OP_COPY  = 2'd3;   // Block copy from source address

endpackage

/* logic/vdc_timing_pkg.sv */
// Raster position types and chip version codes used by the VDC timing logic and register file
package vdc_timing_pkg;

	typedef logic [7:0] col_t;      // Character column on a scan line
	typedef logic [7:0] line_t;     // Scan line in the frame
	typedef logic [1:0] version_t;  // Chip revision strap

	// Chip revisions, R37 exists only on the 8568
	localparam version_t VER_R7A  = 2'd0;  // 8563 R7A
	localparam version_t VER_R9   = 2'd1;  // 8563 R9
	localparam version_t VER_8568 = 2'd2;  // 8568 with sync polarity

endpackage

/* logic/vdc_registers.sv */
// CPU-side register file of the VDC; holds timing registers and turns memory register accesses into RAM commands
`timescale 1ns/1ns

module vdc_registers (
	input  logic                    clk,
	input  logic                    reset,
	input  vdc_timing_pkg::version_t version,
	input  logic                    bus_en,     // Bus strobe, cs/we sampled while high
	input  logic                    cs,
	input  logic                    rs,         // 0 selects address/status, 1 data
	input  logic                    we,
	input  vdc_regs_pkg::db_t       db_in,
	output vdc_regs_pkg::db_t       db_out,
	input  logic                    lp_n,
	input  vdc_timing_pkg::col_t    col,
	input  vdc_timing_pkg::line_t   line,
	input  logic                    visible,
	input  logic [15:0]             ua,
	input  logic [15:0]             ba,
	input  vdc_regs_pkg::db_t       wc,
	input  vdc_regs_pkg::db_t       da,
	output vdc_timing_pkg::col_t    ht,
	output vdc_timing_pkg::col_t    hd,
	output vdc_timing_pkg::col_t    hp,
	output logic [3:0]              hw,
	output vdc_timing_pkg::line_t   vt,
	output vdc_timing_pkg::line_t   vd,
	output vdc_timing_pkg::line_t   vp,
	output logic [3:0]              vw,
	output logic                    copy,
	output logic                    hs_pol,
	output logic                    vs_pol,
	output logic                    mem_req,
	input  logic                    mem_ack,
	output vdc_regs_pkg::mem_op_t   mem_op,
	output vdc_regs_pkg::db_t       mem_data,
	output logic [15:0]             mem_addr,
	output vdc_regs_pkg::db_t       mem_count
);

	vdc_regs_pkg::reg_sel_t reg_sel;    // Register selected through rs=0 writes
	vdc_timing_pkg::line_t  lpv;        // Pen line
	vdc_timing_pkg::col_t   lph;        // Pen column
	logic                   lp_status;  // Pen hit waiting to be read
	logic                   lp_n_q;     // Previous pen level for edge detect
	logic [15:0]            ba_src;     // Copy source as seen by the CPU
	logic                   busy;
	logic                   bus_rd;
	logic                   bus_wr;
	logic                   is_8568;

	assign busy    = mem_req | mem_ack;  // Whole handshake counts as busy
	assign bus_rd  = bus_en & cs & ~we;
	assign bus_wr  = bus_en & cs & we;
	assign is_8568 = (version == vdc_timing_pkg::VER_8568);

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_sel <= '0;
			{ht, hd, hp, hw, vt, vd, vp, vw} <= '0;
			copy      <= 1'b0;
			hs_pol    <= 1'b0;
			vs_pol    <= 1'b0;
			lpv       <= '0;
			lph       <= '0;
			lp_status <= 1'b0;
			lp_n_q    <= 1'b1;      // No false pen edge out of reset
			ba_src    <= '0;
			mem_req   <= 1'b0;
			db_out    <= '0;
		end else begin
			lp_n_q <= lp_n;
			if (mem_req && mem_ack) begin
				mem_req <= 1'b0;                           // Served, release req
				if (mem_op == vdc_regs_pkg::OP_COPY)
					ba_src <= ba;                           // Pick up advanced source
			end

			if (bus_wr) begin
				if (!rs)
					reg_sel <= db_in[5:0];
				else
					case (reg_sel)
						vdc_regs_pkg::R_HT:    ht <= db_in;
						vdc_regs_pkg::R_HD:    hd <= db_in;
						vdc_regs_pkg::R_HP:    hp <= db_in;
						vdc_regs_pkg::R_SYNCW: {vw, hw} <= db_in;
						vdc_regs_pkg::R_VT:    vt <= db_in;
						vdc_regs_pkg::R_VD:    vd <= db_in;
						vdc_regs_pkg::R_VP:    vp <= db_in;
						vdc_regs_pkg::R_MODE:  copy <= db_in[7];
						vdc_regs_pkg::R_BAH:   ba_src[15:8] <= db_in;
						vdc_regs_pkg::R_BAL:   ba_src[7:0] <= db_in;
						vdc_regs_pkg::R_POL: if (is_8568) begin  // Only the 8568 has R37
							hs_pol <= db_in[7];
							vs_pol <= db_in[6];
						end
						vdc_regs_pkg::R_UAH, vdc_regs_pkg::R_UAL: if (!busy) begin
							mem_req  <= 1'b1;                      // New address, reload latch
							mem_op   <= vdc_regs_pkg::OP_LOAD;
							mem_addr <= (reg_sel == vdc_regs_pkg::R_UAH) ?
								{db_in, ua[7:0]} : {ua[15:8], db_in};
						end
						vdc_regs_pkg::R_WC: if (!busy) begin
							mem_req   <= 1'b1;
							mem_op    <= copy ? vdc_regs_pkg::OP_COPY : vdc_regs_pkg::OP_FILL;
							mem_addr  <= copy ? ba_src : ua;       // Source for copy
							mem_count <= db_in;                    // Words minus 1
						end
						vdc_regs_pkg::R_DA: if (!busy) begin
							mem_req  <= 1'b1;
							mem_op   <= vdc_regs_pkg::OP_WRITE;
							mem_addr <= ua;
							mem_data <= db_in;
						end
						default: ;                                // Read-only or dropped
					endcase
			end

			if (bus_rd) begin
				if (!rs)
					db_out <= {~busy, lp_status, ~visible, 3'b000, version};  // Status byte
				else
					case (reg_sel)
						vdc_regs_pkg::R_HT:    db_out <= ht;
						vdc_regs_pkg::R_HD:    db_out <= hd;
						vdc_regs_pkg::R_HP:    db_out <= hp;
						vdc_regs_pkg::R_SYNCW: db_out <= {vw, hw};
						vdc_regs_pkg::R_VT:    db_out <= vt;
						vdc_regs_pkg::R_VD:    db_out <= vd;
						vdc_regs_pkg::R_VP:    db_out <= vp;
						vdc_regs_pkg::R_LPV: begin
							db_out    <= lpv;
							lp_status <= 1'b0;                     // Reading the pen rearms it
						end
						vdc_regs_pkg::R_LPH: begin
							db_out    <= lph;
							lp_status <= 1'b0;
						end
						vdc_regs_pkg::R_UAH:   db_out <= ua[15:8];
						vdc_regs_pkg::R_UAL:   db_out <= ua[7:0];
						vdc_regs_pkg::R_MODE:  db_out <= {copy, 7'h7f};  // Other mode bits not kept
						vdc_regs_pkg::R_WC:    db_out <= wc;
						vdc_regs_pkg::R_DA: begin
							db_out <= da;
							if (!busy) begin
								mem_req  <= 1'b1;                   // Prefetch next word
								mem_op   <= vdc_regs_pkg::OP_LOAD;
								mem_addr <= ua + 16'd1;
							end
						end
						vdc_regs_pkg::R_BAH:   db_out <= ba_src[15:8];
						vdc_regs_pkg::R_BAL:   db_out <= ba_src[7:0];
						vdc_regs_pkg::R_POL:   db_out <= {hs_pol | ~is_8568, vs_pol | ~is_8568, 6'h3f};
						default:               db_out <= 8'hff;
					endcase
			end

			// Pen position on the rising edge, first hit wins
			if (!lp_n_q && lp_n && !lp_status) begin
				lph       <= col;
				lpv       <= line;
				lp_status <= 1'b1;
			end
		end
	end

endmodule

/* logic/vdc_raster_counter.sv */
// Raster counter of the VDC; steps columns and lines from the pixel clock and makes sync and blank levels
`timescale 1ns/1ns

module vdc_raster_counter #(
	parameter int CHAR_PIXELS = 8          // Pixel ticks per character column
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  pixel_en,
	input  vdc_timing_pkg::col_t  ht,
	input  vdc_timing_pkg::col_t  hd,
	input  vdc_timing_pkg::col_t  hp,
	input  logic [3:0]            hw,
	input  vdc_timing_pkg::line_t vt,
	input  vdc_timing_pkg::line_t vd,
	input  vdc_timing_pkg::line_t vp,
	input  logic [3:0]            vw,
	output vdc_timing_pkg::col_t  col,
	output vdc_timing_pkg::line_t line,
	output logic                  hsync,
	output logic                  vsync,
	output logic                  hblank,
	output logic                  vblank,
	output logic                  visible
);

	localparam int PW = (CHAR_PIXELS > 1) ? $clog2(CHAR_PIXELS) : 1;

	logic [PW-1:0]         pix_cnt;   // Pixel tick within the column
	logic                  char_tick; // Last pixel of a column
	logic                  col_wrap;
	vdc_timing_pkg::col_t  col_nx;
	vdc_timing_pkg::line_t line_nx;

	assign char_tick = pixel_en && (pix_cnt == PW'(CHAR_PIXELS - 1));
	assign col_wrap  = (col == ht);
	assign col_nx    = col_wrap ? '0 : col + 8'd1;
	assign line_nx   = !col_wrap ? line : ((line == vt) ? '0 : line + 8'd1);
	assign visible   = ~vblank;

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_cnt <= '0;
			col     <= '0;
			line    <= '0;
			hsync   <= 1'b0;
			vsync   <= 1'b0;
			hblank  <= 1'b0;
			vblank  <= 1'b0;
		end else if (pixel_en) begin
			pix_cnt <= char_tick ? '0 : pix_cnt + PW'(1);
			if (char_tick) begin
				col  <= col_nx;
				line <= line_nx;
				// Levels follow the column or line being entered
				hblank <= (col_nx >= hd);
				hsync  <= ({1'b0, col_nx} >= {1'b0, hp}) &&
					({1'b0, col_nx} < ({1'b0, hp} + {5'd0, hw}));
				vblank <= (line_nx >= vd);
				vsync  <= ({1'b0, line_nx} >= {1'b0, vp}) &&
					({1'b0, line_nx} < ({1'b0, vp} + {5'd0, vw}));
			end
		end
	end

endmodule

/* logic/vdc_ram_sequencer.sv */
// RAM sequencer of the VDC; serves req/ack memory commands and owns update address, data latch, count and source
`timescale 1ns/1ns

module vdc_ram_sequencer #(
	parameter int RAM_ADDR_WIDTH = 14
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        mem_req,
	output logic                        mem_ack,
	input  vdc_regs_pkg::mem_op_t       mem_op,
	input  vdc_regs_pkg::db_t           mem_data,
	input  logic [15:0]                 mem_addr,
	input  vdc_regs_pkg::db_t           mem_count,
	output logic [15:0]                 ua,
	output logic [15:0]                 ba,
	output vdc_regs_pkg::db_t           wc,
	output vdc_regs_pkg::db_t           da,
	output logic [RAM_ADDR_WIDTH-1:0]   ram_addr,
	output logic                        ram_we,
	output vdc_regs_pkg::db_t           ram_wdata,
	input  vdc_regs_pkg::db_t           ram_rdata
);

	localparam logic [16:0] ADDR_SPAN = 17'd1 << RAM_ADDR_WIDTH;
	localparam logic [15:0] ADDR_MASK = 16'(ADDR_SPAN - 17'd1);  // Addresses wrap at RAM size

	typedef enum logic [2:0] {
		S_IDLE, S_LOAD, S_WRITE, S_BREAD, S_BWRITE, S_ACK
	} seq_state_t;

	seq_state_t state;
	logic       blk_copy;  // Block source is RAM, not the latch

	function automatic logic [15:0] wrap(input logic [15:0] a);
		return a & ADDR_MASK;
	endfunction

	assign mem_ack   = (state == S_ACK);  // Only after the last word
	assign ram_we    = (state == S_WRITE) || (state == S_BWRITE);
	assign ram_wdata = (state == S_BWRITE && blk_copy) ? ram_rdata : da;

	always_comb begin
		case (state)
			S_IDLE:  ram_addr = mem_addr[RAM_ADDR_WIDTH-1:0];  // Early read for a load
			S_BREAD: ram_addr = ba[RAM_ADDR_WIDTH-1:0];
			default: ram_addr = ua[RAM_ADDR_WIDTH-1:0];
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= S_IDLE;
			ua       <= '0;
			ba       <= '0;
			wc       <= '0;
			da       <= '0;
			blk_copy <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (mem_req) begin
					case (mem_op)
						vdc_regs_pkg::OP_LOAD: begin
							ua    <= wrap(mem_addr);
							state <= S_LOAD;
						end
						vdc_regs_pkg::OP_WRITE: begin
							ua    <= wrap(mem_addr);
							da    <= mem_data;
							state <= S_WRITE;
						end
						default: begin                    // Fill or copy from current ua
							wc       <= mem_count;
							blk_copy <= (mem_op == vdc_regs_pkg::OP_COPY);
							if (mem_op == vdc_regs_pkg::OP_COPY) begin
								ba    <= wrap(mem_addr);
								state <= S_BREAD;
							end else
								state <= S_BWRITE;
						end
					endcase
				end
				S_LOAD: begin
					da    <= ram_rdata;                 // Read issued in idle
					state <= S_ACK;
				end
				S_WRITE: begin
					ua    <= wrap(ua + 16'd1);
					state <= S_ACK;
				end
				S_BREAD: begin
					ba    <= wrap(ba + 16'd1);
					state <= S_BWRITE;
				end
				S_BWRITE: begin
					ua <= wrap(ua + 16'd1);
					if (blk_copy)
						da <= ram_rdata;                  // Latch ends with last copied byte
					if (wc == '0)
						state <= S_ACK;
					else begin
						wc    <= wc - 8'd1;
						state <= blk_copy ? S_BREAD : S_BWRITE;
					end
				end
				S_ACK: if (!mem_req)
					state <= S_IDLE;                      // Ack falls after req
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* logic/vdc_video_ram.sv */
// Screen memory of the VDC; single-port synchronous RAM with one cycle of read latency
`timescale 1ns/1ns

module vdc_video_ram #(
	parameter int RAM_ADDR_WIDTH = 14
) (
	input  logic                      clk,
	input  logic [RAM_ADDR_WIDTH-1:0] ram_addr,
	input  logic                      ram_we,
	input  vdc_regs_pkg::db_t         ram_wdata,
	output vdc_regs_pkg::db_t         ram_rdata
);

	vdc_regs_pkg::db_t mem [2**RAM_ADDR_WIDTH];  // Screen bytes

	always_ff @(posedge clk) begin
		if (ram_we)
			mem[ram_addr] <= ram_wdata;
		ram_rdata <= mem[ram_addr];                // Old data on a write cycle
	end

endmodule

/* logic/vdc_top.sv */
// Top level of the reduced VDC; joins register file, raster counter, RAM sequencer and video RAM
`timescale 1ns/1ns

module vdc_top #(
	parameter int RAM_ADDR_WIDTH = 14,
	parameter int CHAR_PIXELS    = 8
) (
	input  logic                     clk,
	input  logic                     reset,
	input  vdc_timing_pkg::version_t version,
	input  logic                     bus_en,
	input  logic                     cs,
	input  logic                     rs,
	input  logic                     we,
	input  vdc_regs_pkg::db_t        db_in,
	output vdc_regs_pkg::db_t        db_out,
	input  logic                     lp_n,
	input  logic                     pixel_en,
	output logic                     hsync,
	output logic                     vsync,
	output logic                     hblank,
	output logic                     vblank
);

	vdc_timing_pkg::col_t  ht, hd, hp, col;
	vdc_timing_pkg::line_t vt, vd, vp, line;
	logic [3:0]            hw, vw;
	logic                  hs_pol, vs_pol, visible;
	logic                  hsync_pos, vsync_pos;      // Raster levels before polarity
	logic                  mem_req, mem_ack;
	vdc_regs_pkg::mem_op_t mem_op;
	vdc_regs_pkg::db_t     mem_data, mem_count, wc, da;
	logic [15:0]           mem_addr, ua, ba;
	logic [RAM_ADDR_WIDTH-1:0] ram_addr;
	logic                  ram_we;
	vdc_regs_pkg::db_t     ram_wdata, ram_rdata;

	// Polarity register only acts on the 8568
	assign hsync = hsync_pos ^ (hs_pol && version == vdc_timing_pkg::VER_8568);
	assign vsync = vsync_pos ^ (vs_pol && version == vdc_timing_pkg::VER_8568);

	vdc_registers i_vdc_registers (
		.clk, .reset, .version, .bus_en, .cs, .rs, .we, .db_in, .db_out,
		.lp_n, .col, .line, .visible, .ua, .ba, .wc, .da,
		.ht, .hd, .hp, .hw, .vt, .vd, .vp, .vw, .copy(), .hs_pol, .vs_pol,
		.mem_req, .mem_ack, .mem_op, .mem_data, .mem_addr, .mem_count
	);

	vdc_raster_counter #(.CHAR_PIXELS(CHAR_PIXELS)) i_vdc_raster_counter (
		.clk, .reset, .pixel_en, .ht, .hd, .hp, .hw, .vt, .vd, .vp, .vw,
		.col, .line, .hsync(hsync_pos), .vsync(vsync_pos), .hblank, .vblank, .visible
	);

	vdc_ram_sequencer #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) i_vdc_ram_sequencer (
		.clk, .reset, .mem_req, .mem_ack, .mem_op, .mem_data, .mem_addr, .mem_count,
		.ua, .ba, .wc, .da, .ram_addr, .ram_we, .ram_wdata, .ram_rdata
	);

	vdc_video_ram #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) i_vdc_video_ram (
		.clk, .ram_addr, .ram_we, .ram_wdata, .ram_rdata
	);

endmodule

/* verif/vdc_assert.sv */
// Concurrent checks on the req/ack memory handshake; bound into the VDC RAM sequencer
`timescale 1ns/1ns

module vdc_assert (
	input logic                  clk,
	input logic                  reset,
	input logic                  mem_req,
	input logic                  mem_ack,
	input vdc_regs_pkg::mem_op_t mem_op,
	input vdc_regs_pkg::db_t     mem_data,
	input logic [15:0]           mem_addr,
	input vdc_regs_pkg::db_t     mem_count
);

	// Ack may only answer a pending request
	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(mem_ack) |-> mem_req) else $error("mem_ack rose without mem_req");

	// Request is not withdrawn before it is answered
	req_holds: assert property (@(posedge clk) disable iff (reset)
		mem_req && !mem_ack |=> mem_req) else $error("mem_req fell before mem_ack");

	// Command fields frozen for the life of the request
	fields_stable: assert property (@(posedge clk) disable iff (reset)
		mem_req |=> !mem_req || $stable({mem_op, mem_data, mem_addr, mem_count}))
		else $error("memory command fields changed while mem_req high");

endmodule

bind vdc_ram_sequencer vdc_assert i_vdc_assert (
	.clk(clk), .reset(reset), .mem_req(mem_req), .mem_ack(mem_ack), .mem_op(mem_op),
	.mem_data(mem_data), .mem_addr(mem_addr), .mem_count(mem_count)
);

/* verif/vdc_checker.sv */
// Testbench checker for the VDC; snoops the bus, models the raster and pen, compares reads and sync timing
`timescale 1ns/1ns

module vdc_checker #(
	parameter int CHAR_PIXELS = 8
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              bus_en,
	input  logic              cs,
	input  logic              rs,
	input  logic              we,
	input  vdc_regs_pkg::db_t db_in,
	input  vdc_regs_pkg::db_t db_out,
	input  logic              lp_n,
	input  logic              pixel_en,
	input  logic              hsync,
	input  logic              vsync,
	input  logic              hblank,
	input  logic              vblank,
	input  logic              exp_en,      // Current read cycle is to be compared
	input  vdc_regs_pkg::db_t exp_byte,
	input  vdc_regs_pkg::db_t exp_mask,
	input  logic [1:0]        exp_sel,     // 0 table value, 1 pen line, 2 pen column
	input  logic              meas_en,     // Compare recorded sync timing now
	input  logic [1:0]        meas_sig,    // 0 hsync, 1 vsync, 2 hblank, 3 vblank
	input  int                meas_period, // In clock cycles
	input  int                meas_width,
	output int                rd_errors,
	output int                sync_errors
);

	vdc_regs_pkg::reg_sel_t sel_m;                 // Shadow of the address latch
	vdc_timing_pkg::col_t   ht_m, col_m, pen_col;
	vdc_timing_pkg::line_t  vt_m, line_m, pen_line;
	int                     pix_m;
	logic                   pen_pend, lp_q;
	logic                   pend;                  // Read result due on this edge
	vdc_regs_pkg::db_t      pend_exp, pend_mask, got;
	logic [1:0]             pend_sel;
	logic [3:0]             sigs, prev;
	int                     since_rise [4];
	int                     period [4];
	int                     width [4];

	assign sigs = {vblank, hblank, vsync, hsync};

	always @(posedge clk) begin
		if (reset) begin
			sel_m <= '0; ht_m <= '0; vt_m <= '0;
			col_m <= '0; line_m <= '0; pix_m <= 0;
			pen_pend <= 1'b0; lp_q <= 1'b1; pend <= 1'b0;
			rd_errors <= 0; sync_errors <= 0;
		end else begin
			lp_q <= lp_n;
			if (pixel_en) begin                        // Raster position by counting rule
				if (pix_m == CHAR_PIXELS - 1) begin
					pix_m <= 0;
					col_m <= (col_m == ht_m) ? 8'd0 : col_m + 8'd1;
					if (col_m == ht_m)
						line_m <= (line_m == vt_m) ? 8'd0 : line_m + 8'd1;
				end else
					pix_m <= pix_m + 1;
			end
			if (bus_en && cs && we) begin              // Shadow writes
				if (!rs)
					sel_m <= db_in[5:0];
				else if (sel_m == vdc_regs_pkg::R_HT)
					ht_m <= db_in;
				else if (sel_m == vdc_regs_pkg::R_VT)
					vt_m <= db_in;
			end
			if (pend) begin
				got = (pend_sel == 2'd1) ? pen_line : (pend_sel == 2'd2) ? pen_col : pend_exp;
				if ((db_out & pend_mask) != (got & pend_mask)) begin
					$display("CHECK FAILED at %0t: db_out %h expected %h mask %h",
						$time, db_out, got, pend_mask);
					rd_errors <= rd_errors + 1;
				end
			end
			pend <= 1'b0;
			if (bus_en && cs && !we) begin
				pend      <= exp_en;
				pend_exp  <= exp_byte;
				pend_mask <= exp_mask;
				pend_sel  <= exp_sel;
				if (rs && (sel_m == vdc_regs_pkg::R_LPV || sel_m == vdc_regs_pkg::R_LPH))
					pen_pend <= 1'b0;                  // Pen read rearms the latch
			end
			if (!lp_q && lp_n && !pen_pend) begin      // First rising edge wins
				pen_col  <= col_m;
				pen_line <= line_m;
				pen_pend <= 1'b1;
			end
			if (meas_en && (period[meas_sig] != meas_period || width[meas_sig] != meas_width)) begin
				$display("CHECK FAILED at %0t: sync %0d period %0d width %0d, expected %0d %0d",
					$time, meas_sig, period[meas_sig], width[meas_sig], meas_period, meas_width);
				sync_errors <= sync_errors + 1;
			end
		end
	end

	// Edge to edge cycle counts of each sync and blank output
	always @(posedge clk) begin
		prev <= sigs;
		for (int i = 0; i < 4; i++) begin
			if (sigs[i] && !prev[i]) begin
				period[i]     <= since_rise[i];
				since_rise[i] <= 1;
			end else
				since_rise[i] <= since_rise[i] + 1;
			if (!sigs[i] && prev[i])
				width[i] <= since_rise[i];
		end
	end

endmodule

/* verif/vdc_tb.sv */
// Testbench top for the VDC; builds a stimulus table from the register and memory rules and applies it
`timescale 1ns/1ns

module vdc_tb;

	localparam int CP = 4;                         // Pixel ticks per column in this run
	localparam int RAM_AW = 10;
	localparam int OP_WR = 0, OP_RD = 1, OP_STAT = 2, OP_POLL = 3;
	localparam int OP_PEN = 4, OP_MEAS = 5, OP_VER = 6;

	typedef struct {
		int op;
		int regn;
		int data;   // Write byte, read source select, sync index or version
		int exp;    // Expected byte or period
		int aux;    // Read mask or sync width
	} entry_t;

	logic clk, reset, bus_en, cs, rs, we, lp_n, pixel_en;
	logic hsync, vsync, hblank, vblank;
	vdc_timing_pkg::version_t version;
	vdc_regs_pkg::db_t db_in, db_out, exp_byte, exp_mask, rd_val;
	logic exp_en, meas_en;
	logic [1:0] exp_sel, meas_sig;
	int meas_period, meas_width, rd_errors, sync_errors, run_errors;
	entry_t steps [$];
	logic ready;
	int ram_m [1 << RAM_AW];                     // Expected screen memory
	int m_ua, m_da, m_ver, base, seed_dummy;

	vdc_top #(.RAM_ADDR_WIDTH(RAM_AW), .CHAR_PIXELS(CP)) i_vdc_top (
		.clk, .reset, .version, .bus_en, .cs, .rs, .we, .db_in, .db_out,
		.lp_n, .pixel_en, .hsync, .vsync, .hblank, .vblank
	);

	vdc_checker #(.CHAR_PIXELS(CP)) i_vdc_checker (
		.clk, .reset, .bus_en, .cs, .rs, .we, .db_in, .db_out, .lp_n, .pixel_en,
		.hsync, .vsync, .hblank, .vblank, .exp_en, .exp_byte, .exp_mask, .exp_sel,
		.meas_en, .meas_sig, .meas_period, .meas_width, .rd_errors, .sync_errors
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;                   // 8 ns period
	end

	initial begin
		pixel_en = 1'b0;
		forever begin
			@(posedge clk);
			#1 pixel_en = ~pixel_en;             // One pixel tick every other cycle
		end
	end

	task automatic push(input int op, input int r, input int d, input int e, input int a);
		steps.push_back('{op, r, d, e, a});
	endtask

	task automatic put_write(input int r, input int d);
		push(OP_WR, r, d, 0, 0);
	endtask

	task automatic expect_reg(input int r, input int e, input int sel = 0);
		push(OP_RD, r, sel, e, 8'hff);
	endtask

	task automatic expect_status(input int pen);
		push(OP_STAT, 0, 0, 8'h80 | (pen << 6) | m_ver, 8'hdf);  // Vblank bit ignored
	endtask

	task automatic set_version(input int v);
		m_ver = v;
		push(OP_VER, 0, v, 0, 0);
	endtask

	task automatic set_ua(input int a);
		put_write(vdc_regs_pkg::R_UAH, a >> 8);
		push(OP_POLL, 0, 0, 0, 0);
		put_write(vdc_regs_pkg::R_UAL, a & 8'hff);
		push(OP_POLL, 0, 0, 0, 0);
		m_ua = a;
		m_da = ram_m[a];                         // Load brings the word into the latch
	endtask

	task automatic write_data(input int b);
		put_write(vdc_regs_pkg::R_DA, b);
		push(OP_POLL, 0, 0, 0, 0);
		ram_m[m_ua] = b;
		m_da = b;
		m_ua = (m_ua + 1) % (1 << RAM_AW);
	endtask

	task automatic read_data();
		expect_reg(vdc_regs_pkg::R_DA, m_da);
		push(OP_POLL, 0, 0, 0, 0);
		m_ua = (m_ua + 1) % (1 << RAM_AW);      // Prefetch of the next word
		m_da = ram_m[m_ua];
	endtask

	task automatic check_ua();
		expect_reg(vdc_regs_pkg::R_UAH, m_ua >> 8);
		expect_reg(vdc_regs_pkg::R_UAL, m_ua & 8'hff);
	endtask

	task automatic build_steps();
		int n, src, dst;
		m_ver = 1;
		// Register read-back and R37 per version
		put_write(vdc_regs_pkg::R_SYNCW, 8'h12);
		expect_reg(vdc_regs_pkg::R_SYNCW, 8'h12);
		put_write(vdc_regs_pkg::R_MODE, 8'h80);
		expect_reg(vdc_regs_pkg::R_MODE, 8'hff);
		put_write(vdc_regs_pkg::R_MODE, 8'h00);
		expect_reg(vdc_regs_pkg::R_MODE, 8'h7f);
		expect_reg(5, 8'hff);
		expect_reg(40, 8'hff);
		put_write(vdc_regs_pkg::R_POL, 8'hc0);
		expect_reg(vdc_regs_pkg::R_POL, 8'hff);
		set_version(2);
		expect_reg(vdc_regs_pkg::R_POL, 8'h3f);  // Write under R9 left R37 at zero
		put_write(vdc_regs_pkg::R_POL, 8'h40);
		expect_reg(vdc_regs_pkg::R_POL, 8'h7f);
		put_write(vdc_regs_pkg::R_POL, 8'h00);
		expect_reg(vdc_regs_pkg::R_POL, 8'h3f);
		expect_status(0);
		// Raster of 10 columns and 6 lines with 80 cycles per line
		put_write(vdc_regs_pkg::R_HT, 9);
		put_write(vdc_regs_pkg::R_HD, 6);
		put_write(vdc_regs_pkg::R_HP, 7);
		put_write(vdc_regs_pkg::R_VT, 5);
		put_write(vdc_regs_pkg::R_VD, 4);
		put_write(vdc_regs_pkg::R_VP, 4);
		expect_reg(vdc_regs_pkg::R_HT, 9);
		expect_reg(vdc_regs_pkg::R_VP, 4);
		push(OP_MEAS, 0, 0, 10 * CP * 2, 2 * CP * 2);
		push(OP_MEAS, 0, 1, 6 * 10 * CP * 2, 1 * 10 * CP * 2);
		push(OP_MEAS, 0, 2, 10 * CP * 2, 4 * CP * 2);
		push(OP_MEAS, 0, 3, 6 * 10 * CP * 2, 2 * 10 * CP * 2);
		// Polarity inverts only on the 8568
		put_write(vdc_regs_pkg::R_POL, 8'hc0);
		push(OP_MEAS, 0, 0, 80, 80 - 16);
		push(OP_MEAS, 0, 1, 480, 480 - 80);
		set_version(1);
		push(OP_MEAS, 0, 0, 80, 16);
		push(OP_MEAS, 0, 1, 480, 80);
		expect_reg(vdc_regs_pkg::R_POL, 8'hff);
		// Light pen where a second pulse is ignored until read
		push(OP_PEN, 0, 0, 0, 0);
		expect_status(1);
		push(OP_PEN, 0, 0, 0, 0);
		expect_reg(vdc_regs_pkg::R_LPH, 0, 2);
		expect_reg(vdc_regs_pkg::R_LPV, 0, 1);
		expect_status(0);
		// Single words
		base = $urandom % 512;
		set_ua(base);
		for (int i = 0; i < 5; i++)
			write_data($urandom & 8'hff);
		check_ua();
		set_ua(base);
		for (int i = 0; i < 5; i++)
			read_data();
		check_ua();
		// Block fill from the latch
		write_data($urandom & 8'hff);
		n = 3;
		put_write(vdc_regs_pkg::R_WC, n);
		push(OP_POLL, 0, 0, 0, 0);
		for (int i = 0; i <= n; i++) begin
			ram_m[m_ua] = m_da;
			m_ua = m_ua + 1;
		end
		expect_reg(vdc_regs_pkg::R_WC, 0);
		check_ua();
		// Block copy of the first seven words
		src = base;
		dst = base + 64;
		n = 6;
		put_write(vdc_regs_pkg::R_BAH, src >> 8);
		put_write(vdc_regs_pkg::R_BAL, src & 8'hff);
		put_write(vdc_regs_pkg::R_MODE, 8'h80);
		set_ua(dst);
		put_write(vdc_regs_pkg::R_WC, n);
		push(OP_POLL, 0, 0, 0, 0);
		for (int i = 0; i <= n; i++)
			ram_m[dst + i] = ram_m[src + i];
		m_ua = dst + n + 1;
		expect_reg(vdc_regs_pkg::R_WC, 0);
		check_ua();
		expect_reg(vdc_regs_pkg::R_BAH, (src + n + 1) >> 8);
		expect_reg(vdc_regs_pkg::R_BAL, (src + n + 1) & 8'hff);
		put_write(vdc_regs_pkg::R_MODE, 8'h00);
		set_ua(base + 5);                         // Fill area then copy area
		for (int i = 0; i < 5; i++)
			read_data();
		set_ua(dst);
		for (int i = 0; i <= n; i++)
			read_data();
		expect_status(0);
	endtask

	task automatic write_cycle(input logic r, input int d);
		bus_en = 1'b1;
		cs     = 1'b1;
		we     = 1'b1;
		rs     = r;
		db_in  = 8'(d);
		@(posedge clk);
		#1;
		bus_en = 1'b0;
		cs     = 1'b0;
		we     = 1'b0;
	endtask

	task automatic read_cycle(input logic r, input logic chk, input int e, input int m,
			input int sel, output vdc_regs_pkg::db_t val);
		bus_en   = 1'b1;
		cs       = 1'b1;
		we       = 1'b0;
		rs       = r;
		exp_en   = chk;
		exp_byte = 8'(e);
		exp_mask = 8'(m);
		exp_sel  = 2'(sel);
		@(posedge clk);
		#1;
		bus_en = 1'b0;
		cs     = 1'b0;
		exp_en = 1'b0;
		@(posedge clk);
		#1 val = db_out;                          // Registered read data now valid
	endtask

	task automatic poll_ready();
		int tries;
		tries = 0;
		do begin
			read_cycle(1'b0, 1'b0, 0, 0, 0, rd_val);
			tries++;
		end while (!rd_val[7] && tries < 200);
		if (!rd_val[7]) begin
			$display("Memory command did not finish, status busy after %0d polls at %0t",
				tries, $time);
			run_errors++;
		end
	endtask

	task automatic measure_sync(input int s, input int p, input int w);
		repeat (3) begin
			case (s)
				0: @(posedge hsync);
				1: @(posedge vsync);
				2: @(posedge hblank);
				default: @(posedge vblank);
			endcase
		end
		repeat (2) @(posedge clk);               // Checker records the edge one cycle late
		#1;
		meas_en     = 1'b1;
		meas_sig    = 2'(s);
		meas_period = p;
		meas_width  = w;
		@(posedge clk);
		#1 meas_en = 1'b0;
	endtask

	initial begin
		ready = 1'b0;
		run_errors = 0;
		reset = 1'b1;
		version = vdc_timing_pkg::VER_R9;
		bus_en = 1'b0;
		cs = 1'b0;
		rs = 1'b0;
		we = 1'b0;
		db_in = '0;
		lp_n = 1'b1;
		exp_en = 1'b0;
		exp_byte = '0;
		exp_mask = '0;
		exp_sel = '0;
		meas_en = 1'b0;
		meas_sig = '0;
		meas_period = 0;
		meas_width = 0;
		seed_dummy = $urandom(32'h0ca3_33a9);
		build_steps();
		ready = 1'b1;
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;
		foreach (steps[i]) begin
			case (steps[i].op)
				OP_WR: begin
					write_cycle(1'b0, steps[i].regn);
					write_cycle(1'b1, steps[i].data);
				end
				OP_RD: begin
					write_cycle(1'b0, steps[i].regn);
					read_cycle(1'b1, 1'b1, steps[i].exp, steps[i].aux, steps[i].data, rd_val);
				end
				OP_STAT: read_cycle(1'b0, 1'b1, steps[i].exp, steps[i].aux, 0, rd_val);
				OP_POLL: poll_ready();
				OP_PEN: begin
					lp_n = 1'b0;
					repeat (3) @(posedge clk);
					#1 lp_n = 1'b1;
					repeat (3) @(posedge clk);
					#1;
				end
				OP_MEAS: measure_sync(steps[i].data, steps[i].exp, steps[i].aux);
				default: begin
					version = 2'(steps[i].data);
					@(posedge clk);
					#1;
				end
			endcase
		end
		repeat (2) @(posedge clk);
		$display("errors: read %0d sync %0d run %0d", rd_errors, sync_errors, run_errors);
		if (rd_errors + sync_errors + run_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Watchdog scaled to the table length
	initial begin
		wait (ready);
		repeat (steps.size() * 2000) @(posedge clk);
		$display("Run exceeded its time limit of %0d cycles", steps.size() * 2000);
		$display("sim failed");
		$finish;
	end

endmodule

/* verilog.f */
logic/vdc_regs_pkg.sv
logic/vdc_timing_pkg.sv
logic/vdc_registers.sv
logic/vdc_raster_counter.sv
logic/vdc_ram_sequencer.sv
logic/vdc_video_ram.sv
logic/vdc_top.sv
verif/vdc_assert.sv
verif/vdc_checker.sv
verif/vdc_tb.sv

/* Makefile */
# Verilator build for the VDC testbench; override any variable on the command line

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= vdc_tb
RTL_TOP   ?= vdc_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
